//--- hw/hbm_cfg.svh
`ifndef HBM_CFG_SVH
`define HBM_CFG_SVH

// Number of pseudo-channels in the stack
`define HBM_PSEUDO_CHANNELS 4

// AXI3 address and ID widths
`define HBM_ADDR_WIDTH 33
`define HBM_ID_WIDTH 6

// Bytes per data beat
`define HBM_BEAT_BYTES 32

// Words held by each pseudo-channel memory
`define HBM_PC_WORDS 64

`endif

//--- hw/axi3_pkg.sv
`include "hbm_cfg.svh"

package axi3_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi3_resp_e;

    // Write address channel
    typedef struct packed {
        logic                         valid;
        logic [`HBM_ID_WIDTH-1:0]     id;
        logic [`HBM_ADDR_WIDTH-1:0]   addr;
    } axi3_aw_t;

    // Read address has the same layout
    typedef axi3_aw_t axi3_ar_t;

    typedef struct packed {
        logic                         valid;
        logic                         last;
        logic [`HBM_BEAT_BYTES*8-1:0] data;
    } axi3_w_t;

    typedef struct packed {
        logic                         valid;
        logic [`HBM_ID_WIDTH-1:0]     id;
        axi3_resp_e                   resp;
    } axi3_b_t;

    typedef struct packed {
        logic                         valid;
        logic                         last;
        logic [`HBM_ID_WIDTH-1:0]     id;
        axi3_resp_e                   resp;
        logic [`HBM_BEAT_BYTES*8-1:0] data;
    } axi3_r_t;

endpackage

//--- hw/hbm_pkg.sv
`include "hbm_cfg.svh"

package hbm_pkg;

    localparam int hbm_index_bits  = $clog2(`HBM_PC_WORDS);
    localparam int hbm_offset_bits = $clog2(`HBM_BEAT_BYTES);
    localparam int hbm_upper_bits  = `HBM_ADDR_WIDTH - hbm_index_bits - hbm_offset_bits;

    // One beat as 32 bytes
    typedef logic [`HBM_BEAT_BYTES-1:0][7:0] hbm_word_t;

    typedef logic [hbm_index_bits-1:0] hbm_index_t;

    typedef struct packed {
        logic [hbm_upper_bits-1:0]  upper;
        hbm_index_t                 index;
        logic [hbm_offset_bits-1:0] offset;
    } hbm_addr_fields_t;

    // Same address bits seen flat or split into fields
    typedef union packed {
        logic [`HBM_ADDR_WIDTH-1:0] flat;
        hbm_addr_fields_t           fields;
    } hbm_addr_u;

endpackage

//--- hw/hbm_pc_mem.sv
`timescale 1ns/1ns
`include "hbm_cfg.svh"

module hbm_pc_mem (
    input  logic               axi3_if,
    input  logic               rst,
    input  logic               wr_en,
    input  hbm_pkg::hbm_index_t wr_index,
    input  hbm_pkg::hbm_word_t  wr_data,
    input  logic               rd_en,
    input  hbm_pkg::hbm_index_t rd_index,
    output hbm_pkg::hbm_word_t  rd_data
);

    import hbm_pkg::*;

    hbm_word_t                mem [`HBM_PC_WORDS];
    logic [`HBM_PC_WORDS-1:0] written;

    // Storage array
    always_ff @(posedge axi3_if) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // Tracks which words hold data
    always_ff @(posedge axi3_if) begin
        if (rst) begin
            written <= '0;
        end else if (wr_en) begin
            written[wr_index] <= 1'b1;
        end
    end

    // Registered read, old data on a same-index write
    always_ff @(posedge axi3_if) begin
        if (rd_en) begin
            if (written[rd_index]) begin
                rd_data <= mem[rd_index];
            end else begin
                rd_data <= '0;
            end
        end
    end

endmodule

//--- hw/hbm_pc_write.sv
`timescale 1ns/1ns
`include "hbm_cfg.svh"

module hbm_pc_write (
    input  logic                axi3_if,
    input  logic                rst,
    input  axi3_pkg::axi3_aw_t  aw,
    input  axi3_pkg::axi3_w_t   w,
    output axi3_pkg::axi3_b_t   b,
    output logic                wr_en,
    output hbm_pkg::hbm_index_t wr_index,
    output hbm_pkg::hbm_word_t  wr_data
);

    import axi3_pkg::*;
    import hbm_pkg::*;

    hbm_addr_u                addr_reg;
    logic [`HBM_ID_WIDTH-1:0] id_reg;
    hbm_addr_u                cur_addr;
    logic [`HBM_ID_WIDTH-1:0] cur_id;
    hbm_index_t               base_index;

    logic                     b_valid;
    logic [`HBM_ID_WIDTH-1:0] b_id;

    // Hold the burst address for beats that come later
    always_ff @(posedge axi3_if) begin
        if (aw.valid) begin
            addr_reg.flat <= aw.addr;
            id_reg        <= aw.id;
        end
    end

    // Bypass when address and data arrive together
    assign cur_addr.flat = aw.valid ? aw.addr : addr_reg.flat;
    assign cur_id        = aw.valid ? aw.id : id_reg;
    assign base_index    = cur_addr.fields.index;

    // Second beat lands one word up
    assign wr_en    = w.valid;
    assign wr_index = w.last ? base_index + 1'b1 : base_index;
    assign wr_data  = w.data;

    always_ff @(posedge axi3_if) begin
        if (rst) begin
            b_valid <= 1'b0;
        end else begin
            b_valid <= w.valid && w.last;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (w.valid && w.last) begin
            b_id <= cur_id;
        end
    end

    // Always OKAY
    assign b = '{valid: b_valid, id: b_id, resp: OKAY};

endmodule

//--- hw/hbm_pc_read.sv
`timescale 1ns/1ns
`include "hbm_cfg.svh"

module hbm_pc_read (
    input  logic                axi3_if,
    input  logic                rst,
    input  axi3_pkg::axi3_ar_t  ar,
    output axi3_pkg::axi3_r_t   r,
    output logic                rd_en,
    output hbm_pkg::hbm_index_t rd_index,
    input  hbm_pkg::hbm_word_t  rd_data
);

    import axi3_pkg::*;
    import hbm_pkg::*;

    hbm_addr_u                ar_addr;
    hbm_index_t               next_index;
    logic [`HBM_ID_WIDTH-1:0] id_reg;
    logic                     second_pending;

    // Issue stage, lined up with the memory read
    logic                     issue_valid;
    logic                     issue_last;
    logic [`HBM_ID_WIDTH-1:0] issue_id;

    // Beat stage, lined up with rd_data
    logic                     r_valid;
    logic                     r_last;
    logic [`HBM_ID_WIDTH-1:0] r_id;

    assign ar_addr.flat = ar.addr;

    always_ff @(posedge axi3_if) begin
        if (rst) begin
            second_pending <= 1'b0;
        end else begin
            second_pending <= ar.valid;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (ar.valid) begin
            next_index <= ar_addr.fields.index + 1'b1;
            id_reg     <= ar.id;
        end
    end

    // New burst wins over a pending second read
    assign issue_valid = ar.valid || second_pending;
    assign issue_last  = second_pending && !ar.valid;
    assign issue_id    = ar.valid ? ar.id : id_reg;

    assign rd_en    = issue_valid;
    assign rd_index = ar.valid ? ar_addr.fields.index : next_index;

    always_ff @(posedge axi3_if) begin
        if (rst) begin
            r_valid <= 1'b0;
            r_last  <= 1'b0;
        end else begin
            r_valid <= issue_valid;
            r_last  <= issue_last;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (issue_valid) begin
            r_id <= issue_id;
        end
    end

    assign r = '{
        valid: r_valid,
        last:  r_last,
        id:    r_id,
        resp:  OKAY,
        data:  rd_data
    };

endmodule

//--- hw/hbm_stack.sv
`timescale 1ns/1ns
`include "hbm_cfg.svh"

module hbm_stack #(
    parameter int pseudo_channels = `HBM_PSEUDO_CHANNELS
) (
    input  logic               axi3_if,
    input  logic               rst,
    input  axi3_pkg::axi3_aw_t aw [pseudo_channels],
    input  axi3_pkg::axi3_w_t  w  [pseudo_channels],
    input  axi3_pkg::axi3_ar_t ar [pseudo_channels],
    output axi3_pkg::axi3_b_t  b  [pseudo_channels],
    output axi3_pkg::axi3_r_t  r  [pseudo_channels]
);

    import hbm_pkg::*;

    for (genvar g_pc = 0; g_pc < pseudo_channels; g_pc++) begin : g_pc_blk

        logic       wr_en;
        hbm_index_t wr_index;
        hbm_word_t  wr_data;
        logic       rd_en;
        hbm_index_t rd_index;
        hbm_word_t  rd_data;

        hbm_pc_write hbm_pc_write_inst (
            .axi3_if  (axi3_if),
            .rst      (rst),
            .aw       (aw[g_pc]),
            .w        (w[g_pc]),
            .b        (b[g_pc]),
            .wr_en    (wr_en),
            .wr_index (wr_index),
            .wr_data  (wr_data)
        );

        hbm_pc_read hbm_pc_read_inst (
            .axi3_if  (axi3_if),
            .rst      (rst),
            .ar       (ar[g_pc]),
            .r        (r[g_pc]),
            .rd_en    (rd_en),
            .rd_index (rd_index),
            .rd_data  (rd_data)
        );

        // Private storage per pseudo-channel
        hbm_pc_mem hbm_pc_mem_inst (
            .axi3_if  (axi3_if),
            .rst      (rst),
            .wr_en    (wr_en),
            .wr_index (wr_index),
            .wr_data  (wr_data),
            .rd_en    (rd_en),
            .rd_index (rd_index),
            .rd_data  (rd_data)
        );

    end : g_pc_blk

endmodule

//--- tb/hbm_stack_assertions.sv
`timescale 1ns/1ns
`include "hbm_cfg.svh"

module hbm_stack_assertions #(
    parameter int pseudo_channels = `HBM_PSEUDO_CHANNELS
) (
    input logic               axi3_if,
    input logic               rst,
    input axi3_pkg::axi3_w_t  w  [pseudo_channels],
    input axi3_pkg::axi3_ar_t ar [pseudo_channels],
    input axi3_pkg::axi3_b_t  b  [pseudo_channels],
    input axi3_pkg::axi3_r_t  r  [pseudo_channels]
);

    import axi3_pkg::*;

    for (genvar g_pc = 0; g_pc < pseudo_channels; g_pc++) begin : g_chk

        // Response in the cycle after the last beat, and only then
        b_after_last: assert property (@(posedge axi3_if) disable iff (rst)
            w[g_pc].valid && w[g_pc].last |=> b[g_pc].valid)
            else $error("channel %0d: no write response after last beat", g_pc);

        b_needs_last: assert property (@(posedge axi3_if) disable iff (rst)
            b[g_pc].valid |-> $past(w[g_pc].valid && w[g_pc].last))
            else $error("channel %0d: write response without a last beat", g_pc);

        r_last_valid: assert property (@(posedge axi3_if) disable iff (rst)
            r[g_pc].last |-> r[g_pc].valid)
            else $error("channel %0d: read last without read valid", g_pc);

        // Read pipeline takes a new burst every other cycle at most
        ar_spacing: assert property (@(posedge axi3_if) disable iff (rst)
            ar[g_pc].valid |=> !ar[g_pc].valid)
            else $error("channel %0d: read address in consecutive cycles", g_pc);

        b_okay: assert property (@(posedge axi3_if) disable iff (rst)
            b[g_pc].valid |-> b[g_pc].resp == OKAY)
            else $error("channel %0d: write response not OKAY", g_pc);

        r_okay: assert property (@(posedge axi3_if) disable iff (rst)
            r[g_pc].valid |-> r[g_pc].resp == OKAY)
            else $error("channel %0d: read response not OKAY", g_pc);

    end : g_chk

endmodule

bind hbm_stack hbm_stack_assertions #(
    .pseudo_channels (pseudo_channels)
) hbm_stack_assertions_inst (
    .axi3_if (axi3_if),
    .rst     (rst),
    .w       (w),
    .ar      (ar),
    .b       (b),
    .r       (r)
);

//--- tb/hbm_stack_tb.sv
`timescale 1ns/1ns
`include "hbm_cfg.svh"

module hbm_stack_tb;

    import axi3_pkg::*;
    import hbm_pkg::*;

    localparam int channels    = `HBM_PSEUDO_CHANNELS;
    localparam int words       = `HBM_PC_WORDS;
    localparam int data_bits   = `HBM_BEAT_BYTES * 8;
    localparam int index_shift = $clog2(`HBM_BEAT_BYTES);
    localparam int upper_shift = index_shift + $clog2(`HBM_PC_WORDS);
    localparam int timeout     = 20;

    typedef logic [data_bits-1:0]         data_t;
    typedef logic [`HBM_ID_WIDTH-1:0]     id_t;
    typedef logic [`HBM_ADDR_WIDTH-1:0]   addr_t;

    logic     axi3_if;
    logic     rst;
    axi3_aw_t aw [channels];
    axi3_w_t  w  [channels];
    axi3_ar_t ar [channels];
    axi3_b_t  b  [channels];
    axi3_r_t  r  [channels];

    // One reference memory per channel
    data_t ref_mem     [channels][words];
    logic  ref_written [channels][words];

    hbm_stack #(
        .pseudo_channels (channels)
    ) hbm_stack_inst (
        .axi3_if (axi3_if),
        .rst     (rst),
        .aw      (aw),
        .w       (w),
        .ar      (ar),
        .b       (b),
        .r       (r)
    );

    always #50 axi3_if = ~axi3_if;

    // Inputs change and outputs are sampled 5 ns after the edge
    task automatic next_cycle();
        @(posedge axi3_if);
        #5;
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    function automatic data_t random_word();
        data_t word;
        for (int i = 0; i < data_bits / 32; i++) begin
            word[i*32 +: 32] = $urandom;
        end
        return word;
    endfunction

    // Address with random upper bits and a zero byte offset
    function automatic addr_t make_addr(input int index);
        hbm_addr_u addr;
        addr.flat = (addr_t'($urandom_range(0, 255)) << upper_shift)
                  | (addr_t'(index) << index_shift);
        return addr.flat;
    endfunction

    function automatic data_t expected_word(input int ch, input int index);
        if (ref_written[ch][index]) begin
            return ref_mem[ch][index];
        end
        return '0;
    endfunction

    // Idle address channels carry a different address and ID
    task automatic drop_write_address(input int ch, input int index, input id_t id);
        aw[ch] = '{valid: 1'b0, id: ~id, addr: make_addr((index + 17) % words)};
    endtask

    task automatic drop_read_address(input int ch, input int index, input id_t id);
        ar[ch] = '{valid: 1'b0, id: ~id, addr: make_addr((index + 17) % words)};
    endtask

    task automatic wait_b_valid(input int ch);
        int count;
        count = 0;
        while (!b[ch].valid) begin
            if (count == timeout) begin
                fail_run($sformatf("timeout: no write response on channel %0d", ch));
            end else begin
                next_cycle();
                count++;
            end
        end
    endtask

    task automatic wait_r_valid(input int ch);
        int count;
        count = 0;
        while (!r[ch].valid) begin
            if (count == timeout) begin
                fail_run($sformatf("timeout: no read data on channel %0d", ch));
            end else begin
                next_cycle();
                count++;
            end
        end
    endtask

    task automatic check_beat(input int ch, input id_t id, input int index, input logic last);
        check_value($sformatf("r[%0d].valid", ch), data_t'(r[ch].valid), data_t'(1'b1));
        check_value($sformatf("r[%0d].last", ch), data_t'(r[ch].last), data_t'(last));
        check_value($sformatf("r[%0d].id", ch), data_t'(r[ch].id), data_t'(id));
        check_value($sformatf("r[%0d].resp", ch), data_t'(r[ch].resp), data_t'(OKAY));
        check_value($sformatf("r[%0d].data", ch), r[ch].data, expected_word(ch, index));
    endtask

    // gap is the number of idle cycles between address and first beat
    task automatic write_burst(input int ch, input int index, input id_t id, input int gap);
        data_t d0;
        data_t d1;
        d0 = random_word();
        d1 = random_word();
        aw[ch] = '{valid: 1'b1, id: id, addr: make_addr(index)};
        if (gap > 0) begin
            next_cycle();
            drop_write_address(ch, index, id);
            repeat (gap) next_cycle();
        end
        w[ch] = '{valid: 1'b1, last: 1'b0, data: d0};
        next_cycle();
        drop_write_address(ch, index, id);
        w[ch] = '{valid: 1'b1, last: 1'b1, data: d1};
        next_cycle();
        w[ch].valid = 1'b0;
        w[ch].last = 1'b0;
        wait_b_valid(ch);
        check_value($sformatf("b[%0d].id", ch), data_t'(b[ch].id), data_t'(id));
        check_value($sformatf("b[%0d].resp", ch), data_t'(b[ch].resp), data_t'(OKAY));
        next_cycle();
        check_value($sformatf("b[%0d].valid", ch), data_t'(b[ch].valid), data_t'(1'b0));
        ref_mem[ch][index] = d0;
        ref_written[ch][index] = 1'b1;
        ref_mem[ch][(index + 1) % words] = d1;
        ref_written[ch][(index + 1) % words] = 1'b1;
    endtask

    task automatic read_burst(input int ch, input int index, input id_t id);
        ar[ch] = '{valid: 1'b1, id: id, addr: make_addr(index)};
        next_cycle();
        drop_read_address(ch, index, id);
        wait_r_valid(ch);
        check_beat(ch, id, index, 1'b0);
        next_cycle();
        check_beat(ch, id, (index + 1) % words, 1'b1);
        next_cycle();
        check_value($sformatf("r[%0d].valid", ch), data_t'(r[ch].valid), data_t'(1'b0));
    endtask

    task automatic idle_after_reset();
        repeat (5) begin
            next_cycle();
            for (int ch = 0; ch < channels; ch++) begin
                check_value($sformatf("b[%0d].valid", ch), data_t'(b[ch].valid), '0);
                check_value($sformatf("r[%0d].valid", ch), data_t'(r[ch].valid), '0);
            end
        end
    endtask

    task automatic write_then_read();
        write_burst(0, 3, id_t'(6'h15), 0);
        read_burst(0, 3, id_t'(6'h2a));
    endtask

    task automatic held_address_write();
        write_burst(1, 10, id_t'(6'h07), 3);
        read_burst(1, 10, id_t'(6'h08));
    endtask

    task automatic unwritten_read();
        read_burst(2, 40, id_t'(6'h3f));
    endtask

    task automatic channel_isolation();
        for (int ch = 0; ch < channels; ch++) begin
            write_burst(ch, 20, id_t'(ch + 1), 0);
        end
        for (int ch = 0; ch < channels; ch++) begin
            read_burst(ch, 20, id_t'(ch + 32));
        end
    endtask

    // New burst accepted while the previous one sends its second beat
    task automatic back_to_back_reads();
        int  idx_list [4];
        id_t ids [4];
        idx_list = '{30, 32, 34, 63};
        for (int k = 0; k < 4; k++) begin
            ids[k] = id_t'(k + 9);
            write_burst(3, idx_list[k], id_t'(k + 50), 0);
        end
        ar[3] = '{valid: 1'b1, id: ids[0], addr: make_addr(idx_list[0])};
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            drop_read_address(3, idx_list[k], ids[k]);
            wait_r_valid(3);
            check_beat(3, ids[k], idx_list[k], 1'b0);
            next_cycle();
            check_beat(3, ids[k], (idx_list[k] + 1) % words, 1'b1);
            if (k < 3) begin
                ar[3] = '{valid: 1'b1, id: ids[k + 1], addr: make_addr(idx_list[k + 1])};
            end
        end
        next_cycle();
        check_value("r[3].valid", data_t'(r[3].valid), '0);
    endtask

    initial begin
        void'($urandom(79));
        axi3_if = 1'b0;
        rst = 1'b1;
        for (int ch = 0; ch < channels; ch++) begin
            aw[ch] = '0;
            w[ch] = '0;
            ar[ch] = '0;
            for (int i = 0; i < words; i++) begin
                ref_written[ch][i] = 1'b0;
            end
        end
        repeat (10) @(posedge axi3_if);
        #5;
        rst = 1'b0;
        idle_after_reset();
        write_then_read();
        held_address_write();
        unwritten_read();
        channel_isolation();
        back_to_back_reads();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hw
hw/axi3_pkg.sv
hw/hbm_pkg.sv
hw/hbm_pc_mem.sv
hw/hbm_pc_write.sv
hw/hbm_pc_read.sv
hw/hbm_stack.sv
tb/hbm_stack_assertions.sv
tb/hbm_stack_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := hbm_stack_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides the result, the exit code of the run is hidden by tee
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
